// File: common/seg_mem_pkg.sv
`default_nettype none

package seg_mem_pkg;

    // the scratchpad is built for one geometry only
    localparam int data_width_lp    = 64;                              // full SRAM word
    localparam int els_lp           = 256;                             // words in the array
    localparam int num_subbank_lp   = 4;                               // logical slices of the word
    localparam int subbank_width_lp = data_width_lp / num_subbank_lp;  // 16 bits per slice
    localparam int mask_width_lp    = subbank_width_lp / 8;            // one mask bit per byte
    localparam int addr_width_lp    = $clog2(els_lp);                  // 8 address bits

    // one enable bit per subbank
    typedef logic [num_subbank_lp-1:0] subbank_v_t;

    // byte write masks grouped by subbank so lane i lines up with data lane i
    typedef logic [num_subbank_lp-1:0][mask_width_lp-1:0] subbank_mask_t;

    // a memory word seen as its subbank lanes, lane 0 in the low bits
    typedef logic [num_subbank_lp-1:0][subbank_width_lp-1:0] subbank_data_t;

    // request as sent by the requester
    // all subbanks share addr and w, v picks which subbanks take part
    typedef struct packed {
        subbank_v_t               v;       // subbanks touched by this request
        logic                     w;       // high for a write, low for a read
        logic [addr_width_lp-1:0] addr;    // word address shared by every subbank
        subbank_mask_t            w_mask;  // per byte write enables, ignored on reads
        subbank_data_t            data;    // write data, ignored on reads
    } mem_req_t;

    // response to a read
    typedef struct packed {
        subbank_data_t data;  // fresh data in read lanes, last read data elsewhere
        subbank_v_t    v;     // the subbanks that were actually read
    } mem_resp_t;

endpackage

`default_nettype wire

// File: source/seg_mem_byte_mask_sram.sv
`default_nettype none

// behavioral model of the wide single port macro
// one access per cycle, either a read or a masked write
module seg_mem_byte_mask_sram (
    input  wire logic                                 clk_i,
    input  wire logic                                 v_i,       // access enable
    input  wire logic                                 w_i,       // write when high
    input  wire logic [seg_mem_pkg::addr_width_lp-1:0] addr_i,
    input  wire seg_mem_pkg::subbank_data_t           data_i,
    input  wire seg_mem_pkg::subbank_mask_t           w_mask_i,  // one bit per byte
    output seg_mem_pkg::subbank_data_t                data_o     // registered read data
);

    import seg_mem_pkg::*;

    // storage array, no reset like a real macro
    subbank_data_t mem_r [els_lp];

    // write port
    // each mask bit guards one byte of its lane, unmasked bytes keep their contents
    always_ff @(posedge clk_i) begin
        if (v_i && w_i) begin
            for (int i = 0; i < num_subbank_lp; i++) begin
                for (int j = 0; j < mask_width_lp; j++) begin
                    if (w_mask_i[i][j]) begin
                        mem_r[addr_i][i][j*8 +: 8] <= data_i[i][j*8 +: 8];  // byte j of lane i
                    end
                end
            end
        end
    end

    // read port
    // the word shows up one cycle after the enabled edge
    // on cycles without a read the output just keeps whatever it had, which callers
    // must treat as undefined
    always_ff @(posedge clk_i) begin
        if (v_i && !w_i) begin
            data_o <= mem_r[addr_i];
        end
    end

endmodule

`default_nettype wire

// File: seg_mem/seg_mem_segmented.sv
`default_nettype none

// one wide SRAM cut across its width into logical subbanks
// all subbanks share the address and the direction, only the enables differ
// every subbank remembers its last read so unread lanes return stable old data
module seg_mem_segmented (
    input  wire logic                                 clk_i,
    input  wire logic                                 rst_i,
    input  wire seg_mem_pkg::subbank_v_t              v_i,       // per subbank enables
    input  wire logic                                 w_i,       // shared direction
    input  wire logic [seg_mem_pkg::addr_width_lp-1:0] addr_i,   // shared address
    input  wire seg_mem_pkg::subbank_mask_t           w_mask_i,  // byte masks per subbank
    input  wire seg_mem_pkg::subbank_data_t           data_i,    // write data per subbank
    output seg_mem_pkg::subbank_data_t                data_o     // read data per subbank
);

    import seg_mem_pkg::*;

    subbank_mask_t w_mask_lo;   // byte masks after subbank gating
    subbank_data_t sram_data;   // raw macro output, only valid right after a read
    subbank_v_t    read_en;     // subbanks being read on this edge
    subbank_v_t    read_en_r;   // subbanks read on the previous edge
    subbank_data_t last_data_r; // last value returned by each subbank

    // a disabled subbank must not see any byte of a write
    // so its mask lane is forced to zero before it reaches the macro
    always_comb begin
        for (int i = 0; i < num_subbank_lp; i++) begin
            w_mask_lo[i] = w_mask_i[i] & {mask_width_lp{v_i[i]}};
        end
    end

    // the macro is enabled whenever any subbank wants it
    seg_mem_byte_mask_sram sram (
        .clk_i    (clk_i),
        .v_i      (|v_i),        // one access covers every enabled subbank
        .w_i      (w_i),
        .addr_i   (addr_i),
        .data_i   (data_i),
        .w_mask_i (w_mask_lo),
        .data_o   (sram_data)
    );

    assign read_en = v_i & {num_subbank_lp{~w_i}};  // a read only counts for enabled lanes

    // remember which subbanks were read so the next cycle knows whose data is fresh
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            read_en_r <= '0;
        end else begin
            read_en_r <= read_en;
        end
    end

    // per subbank capture with bypass
    // in the cycle after a read the macro data goes straight out and is captured
    // on the same edge that ends the cycle
    // otherwise the lane keeps showing its captured value
    for (genvar i = 0; i < num_subbank_lp; i++) begin : g_lane

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                last_data_r[i] <= '0;  // never read since reset reads as zero
            end else if (read_en_r[i]) begin
                last_data_r[i] <= sram_data[i];
            end
        end

        assign data_o[i] = read_en_r[i] ? sram_data[i] : last_data_r[i];  // bypass when fresh

    end

endmodule

`default_nettype wire

// File: source/seg_mem_req_ctrl.sv
`default_nettype none

// valid/ready front end of the scratchpad
// holds at most one read response, and only takes a new request when that slot is free
// or is being emptied in the same cycle
module seg_mem_req_ctrl (
    input  wire logic                                 clk_i,
    input  wire logic                                 rst_i,
    input  wire seg_mem_pkg::mem_req_t                req_i,
    input  wire logic                                 req_valid_i,
    output logic                                      req_ready_o,
    output seg_mem_pkg::mem_resp_t                    resp_o,
    output logic                                      resp_valid_o,
    input  wire logic                                 resp_ready_i,
    output seg_mem_pkg::subbank_v_t                   mem_v_o,       // zero unless accepted
    output logic                                      mem_w_o,
    output logic [seg_mem_pkg::addr_width_lp-1:0]     mem_addr_o,
    output seg_mem_pkg::subbank_mask_t                mem_w_mask_o,
    output seg_mem_pkg::subbank_data_t                mem_data_o,
    input  wire seg_mem_pkg::subbank_data_t           mem_rdata_i    // held stable by the memory
);

    import seg_mem_pkg::*;

    logic       accept;          // a request transfers on this edge
    logic       read_accept;     // that request is a read of at least one subbank
    logic       resp_pending_r;  // a response sits on the output
    subbank_v_t resp_v_r;        // subbanks covered by the pending response

    // the slot frees up when nothing is held or the consumer takes it right now
    assign req_ready_o = !resp_pending_r || resp_ready_i;

    assign accept      = req_valid_i && req_ready_o;
    assign read_accept = accept && !req_i.w && (|req_i.v);  // empty enables make no response

    // memory controls only carry the request on the accepting cycle
    // so a stalled request never touches the array twice
    always_comb begin
        if (accept) begin
            mem_v_o      = req_i.v;
            mem_w_o      = req_i.w;
            mem_addr_o   = req_i.addr;
            mem_w_mask_o = req_i.w_mask;
            mem_data_o   = req_i.data;
        end else begin
            mem_v_o      = '0;
            mem_w_o      = 1'b0;
            mem_addr_o   = '0;
            mem_w_mask_o = '0;
            mem_data_o   = '0;
        end
    end

    // response slot
    // a new read refills it in the same edge the old response leaves
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            resp_pending_r <= 1'b0;
        end else if (read_accept) begin
            resp_pending_r <= 1'b1;  // data arrives from the memory one cycle later
        end else if (resp_ready_i) begin
            resp_pending_r <= 1'b0;  // consumed, or nothing was there
        end
    end

    // enables of the read in flight, only meaningful while the slot is full
    always_ff @(posedge clk_i) begin
        if (read_accept) begin
            resp_v_r <= req_i.v;
        end
    end

    // the segmented memory bypasses fresh lanes and then holds them,
    // and no new read can start while the slot waits, so the data stays put under back-pressure
    assign resp_o.data  = mem_rdata_i;
    assign resp_o.v     = resp_v_r;
    assign resp_valid_o = resp_pending_r;

endmodule

`default_nettype wire

// File: source/seg_mem_top.sv
`default_nettype none

// scratchpad top, front end controller in front of the segmented memory
module seg_mem_top (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    input  wire seg_mem_pkg::mem_req_t  req_i,
    input  wire logic                   req_valid_i,
    output logic                        req_ready_o,
    output seg_mem_pkg::mem_resp_t      resp_o,
    output logic                        resp_valid_o,
    input  wire logic                   resp_ready_i
);

    import seg_mem_pkg::*;

    subbank_v_t               mem_v;       // gated subbank enables
    logic                     mem_w;
    logic [addr_width_lp-1:0] mem_addr;
    subbank_mask_t            mem_w_mask;
    subbank_data_t            mem_data;
    subbank_data_t            mem_rdata;   // lane data back to the controller

    seg_mem_req_ctrl ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (req_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .resp_o       (resp_o),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .mem_v_o      (mem_v),
        .mem_w_o      (mem_w),
        .mem_addr_o   (mem_addr),
        .mem_w_mask_o (mem_w_mask),
        .mem_data_o   (mem_data),
        .mem_rdata_i  (mem_rdata)
    );

    seg_mem_segmented mem (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .v_i      (mem_v),
        .w_i      (mem_w),
        .addr_i   (mem_addr),
        .w_mask_i (mem_w_mask),
        .data_i   (mem_data),
        .data_o   (mem_rdata)
    );

endmodule

`default_nettype wire

// File: testbench/seg_mem_tb.sv
`default_nettype none

module seg_mem_tb;

    import seg_mem_pkg::*;

    localparam int timeout_cycles_lp = 64;  // longest wait for any handshake

    logic      clk;
    logic      rst;
    mem_req_t  req;
    logic      req_valid;
    logic      req_ready;
    mem_resp_t resp;
    logic      resp_valid;
    logic      resp_ready;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng = 32'd3086;  // xorshift state

    // the reference model is a shadow of the array plus the last value each lane returned
    subbank_data_t shadow [els_lp];
    subbank_data_t last_lane = '0;
    mem_resp_t     want_q [$];   // expected responses in request order
    mem_resp_t     want;
    mem_resp_t     held_resp;    // response seen while the consumer stalled
    logic          held = 1'b0;
    logic          read_sent = 1'b0;  // a read was accepted on the last edge

    seg_mem_top i_dut (
        .clk_i        (clk),
        .rst_i        (rst),
        .req_i        (req),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .resp_o       (resp),
        .resp_valid_o (resp_valid),
        .resp_ready_i (resp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    function automatic mem_req_t make_req(input subbank_v_t v, input logic w,
                                          input logic [addr_width_lp-1:0] addr,
                                          input subbank_mask_t mask, input subbank_data_t data);
        mem_req_t r;
        r.v      = v;
        r.w      = w;
        r.addr   = addr;
        r.w_mask = mask;
        r.data   = data;
        return r;
    endfunction

    task automatic check_val(input string name, input logic [67:0] got, input logic [67:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // applies an accepted request to the model by the byte mask and subbank rules
    task automatic update_model(input mem_req_t r);
        mem_resp_t e;
        if (r.w) begin
            for (int i = 0; i < num_subbank_lp; i++) begin
                for (int j = 0; j < mask_width_lp; j++) begin
                    if (r.v[i] && r.w_mask[i][j]) begin
                        shadow[r.addr][i][j*8 +: 8] = r.data[i][j*8 +: 8];
                    end
                end
            end
        end else if (r.v != '0) begin  // an empty read makes no response
            e.v = r.v;
            for (int i = 0; i < num_subbank_lp; i++) begin
                if (r.v[i]) last_lane[i] = shadow[r.addr][i];  // only read lanes move on
                e.data[i] = last_lane[i];
            end
            want_q.push_back(e);
            read_sent = 1'b1;
        end
    endtask

    // the response monitor samples everything at the falling edge where it is stable
    always @(negedge clk) begin
        if (!rst) begin
            if (resp_valid) begin
                if (held) check_val("resp_o (held)", 68'(resp), 68'(held_resp));
                if (resp_ready) begin
                    checks++;
                    assert (want_q.size() != 0) else begin
                        $display("a response came out with no read outstanding");
                        errors++;
                    end
                    if (want_q.size() != 0) begin
                        want = want_q.pop_front();
                        check_val("resp_o.data", 68'(resp.data), 68'(want.data));
                        check_val("resp_o.v", 68'(resp.v), 68'(want.v));
                    end
                    held = 1'b0;
                end else begin
                    check_val("req_ready_o", 68'(req_ready), 68'(1'b0));  // slot is full
                    held      = 1'b1;
                    held_resp = resp;
                end
            end
            if (read_sent) check_val("resp_valid_o", 68'(resp_valid), 68'(1'b1));
            read_sent = 1'b0;
            if (req_valid && req_ready) update_model(req);  // transfers on the next rising edge
        end
    end

    // called on a rising edge, returns on the edge where the request transfers
    task automatic send_req(input mem_req_t r, output int stalls);
        int cnt;
        req       <= r;
        req_valid <= 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!req_ready && cnt < timeout_cycles_lp) begin
            @(negedge clk);
            cnt++;
        end
        stalls = cnt;
        checks++;
        assert (req_ready) else begin
            $display("timed out waiting for req_ready_o");
            errors++;
        end
        @(posedge clk);
    endtask

    // drops valid and waits until every expected response has been consumed
    task automatic finish_stream();
        int cnt;
        req_valid <= 1'b0;
        cnt = 0;
        @(negedge clk);
        while ((want_q.size() != 0 || resp_valid) && cnt < timeout_cycles_lp) begin
            @(negedge clk);
            cnt++;
        end
        checks++;
        assert (want_q.size() == 0 && !resp_valid) else begin
            $display("timed out waiting for the outstanding responses");
            errors++;
        end
        @(posedge clk);
    endtask

    task automatic report_test(input string name, input int e0);
        $display("%s: %0d errors", name, errors - e0);
    endtask

    task automatic reset_and_fill();
        int          e0;
        int          stalls;
        logic [31:0] r0;
        logic [31:0] r1;
        e0 = errors;
        @(negedge clk);
        check_val("resp_valid_o", 68'(resp_valid), 68'(1'b0));
        check_val("req_ready_o", 68'(req_ready), 68'(1'b1));
        @(posedge clk);
        for (int a = 0; a < els_lp; a++) begin  // every word gets known contents
            next_rand(r0);
            next_rand(r1);
            send_req(make_req(4'hf, 1'b1, 8'(a), '1, {r0, r1}), stalls);
        end
        for (int k = 0; k < 8; k++) begin
            next_rand(r0);
            send_req(make_req(4'hf, 1'b0, r0[7:0], '0, '0), stalls);
        end
        finish_stream();
        report_test("reset state", e0);
    endtask

    task automatic masked_writes();
        int          e0;
        int          stalls;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [7:0]  addrs [16];
        e0 = errors;
        for (int k = 0; k < 16; k++) begin
            next_rand(r0);
            next_rand(r1);
            next_rand(r2);
            addrs[k] = r0[7:0];
            send_req(make_req(4'hf, 1'b1, r0[7:0], r0[15:8], {r1, r2}), stalls);
        end
        for (int k = 0; k < 16; k++) send_req(make_req(4'hf, 1'b0, addrs[k], '0, '0), stalls);
        finish_stream();
        report_test("byte-masked writes", e0);
    endtask

    task automatic enable_gating();
        int          e0;
        int          stalls;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        subbank_v_t  v;
        logic [7:0]  addrs [16];
        e0 = errors;
        for (int k = 0; k < 16; k++) begin
            next_rand(r0);
            next_rand(r1);
            next_rand(r2);
            v = r0[19:16];
            if (v == 4'hf || v == 4'h0) v = 4'h6;  // keep some lanes disabled
            addrs[k] = r0[7:0];
            send_req(make_req(v, 1'b1, r0[7:0], '1, {r1, r2}), stalls);
        end
        for (int k = 0; k < 16; k++) send_req(make_req(4'hf, 1'b0, addrs[k], '0, '0), stalls);
        finish_stream();
        report_test("subbank-enable gating", e0);
    endtask

    task automatic last_read_hold();
        int          e0;
        int          stalls;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        subbank_v_t  v;
        e0 = errors;
        for (int k = 0; k < 24; k++) begin
            next_rand(r0);
            v = r0[11:8];
            if (v == 4'h0) v = 4'h1;
            send_req(make_req(v, 1'b0, r0[7:0], '0, '0), stalls);  // unread lanes hold
            if (r0[12]) begin  // a write in between must leave the held lanes alone
                next_rand(r1);
                next_rand(r2);
                send_req(make_req(4'hf, 1'b1, r1[7:0], '1, {r1, r2}), stalls);
            end
        end
        finish_stream();
        report_test("last-read holding", e0);
    endtask

    task automatic back_pressure();
        int          e0;
        int          stalls;
        logic [31:0] r0;
        logic [7:0]  addrs [20];
        subbank_v_t  vs [20];
        int          stretch [40];
        logic        lvl;
        logic        sends_done;
        e0 = errors;
        // addresses, enables and stall lengths for the whole run
        for (int k = 0; k < 20; k++) begin
            next_rand(r0);
            addrs[k] = r0[7:0];
            vs[k]    = (r0[11:8] == 4'h0) ? 4'h8 : r0[11:8];
        end
        for (int k = 0; k < 40; k++) begin
            next_rand(r0);
            stretch[k] = int'(r0[1:0]) + 1;  // one to four cycles
        end
        sends_done = 1'b0;
        lvl        = 1'b0;
        fork
            begin
                for (int k = 0; k < 20; k++) begin
                    send_req(make_req(vs[k], 1'b0, addrs[k], '0, '0), stalls);
                end
                req_valid  <= 1'b0;
                sends_done = 1'b1;
            end
            begin
                for (int k = 0; k < 40 && !sends_done; k++) begin
                    resp_ready <= lvl;
                    repeat (stretch[k]) @(posedge clk);
                    lvl = !lvl;
                end
                resp_ready <= 1'b1;
            end
        join
        finish_stream();
        report_test("back-pressure", e0);
    endtask

    task automatic back_to_back_reads();
        int          e0;
        int          stalls;
        int          total;
        logic [31:0] r0;
        subbank_v_t  v;
        e0 = errors;
        total = 0;
        for (int k = 0; k < 16; k++) begin
            next_rand(r0);
            v = (r0[11:8] == 4'h0) ? 4'hf : r0[11:8];
            send_req(make_req(v, 1'b0, r0[7:0], '0, '0), stalls);
            total += stalls;
        end
        checks++;
        assert (total == 0) else begin
            $display("req_ready_o dropped %0d times while reads streamed", total);
            errors++;
        end
        finish_stream();
        report_test("back-to-back reads", e0);
    endtask

    initial begin
        rst        = 1'b1;
        req        = '0;
        req_valid  = 1'b0;
        resp_ready = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        reset_and_fill();
        masked_writes();
        enable_gating();
        last_read_hold();
        back_pressure();
        back_to_back_reads();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
common/seg_mem_pkg.sv
source/seg_mem_byte_mask_sram.sv
seg_mem/seg_mem_segmented.sv
source/seg_mem_req_ctrl.sv
source/seg_mem_top.sv
testbench/seg_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the scratchpad testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module seg_mem_tb \
    -f files.f \
    -o seg_mem_sim

./obj_dir/seg_mem_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"
